// ==== files.f ====
rtl/core_pkg.sv
rtl/fetch_ctrl.sv
rtl/execute_stage.sv
rtl/reg_file.sv
rtl/retire_counter.sv
rtl/core_top.sv
tb/tb_core.sv

// ==== rtl/core_pkg.sv ====
package core_pkg;

    // datapath widths
    parameter int XLEN      = 32;
    parameter int INST_W    = 32;
    parameter int REG_IDX_W = 5;

    // major opcodes
    parameter logic [6:0] OPC_OP     = 7'h33;
    parameter logic [6:0] OPC_OP_IMM = 7'h13;
    parameter logic [6:0] OPC_LUI    = 7'h37;
    // reference trap opcode, used here as halt
    parameter logic [6:0] OPC_HALT   = 7'h6b;

    // funct3 of the kept alu ops, shared by OP and OP-IMM
    parameter logic [2:0] F3_ADD = 3'b000;
    parameter logic [2:0] F3_XOR = 3'b100;
    parameter logic [2:0] F3_OR  = 3'b110;
    parameter logic [2:0] F3_AND = 3'b111;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        // operand b straight through, for lui
        ALU_PASS_B = 3'd5
    } alu_op_e;

    // fetch to execute, 65 bits
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [INST_W-1:0] inst;
    } fetch_pkt_t;

    // retired instruction, 71 bits
    typedef struct packed {
        logic                 valid;
        logic                 wen;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
        logic [XLEN-1:0]      pc;
    } commit_t;

endpackage

// ==== rtl/core_top.sv ====
module core_top #(
    parameter logic [core_pkg::XLEN-1:0] PC_START = '0,
    parameter int                        CNT_W    = 32
) (
    input  logic                        mem2wb_inst_selfdefine_o,
    input  logic                        reset,
    input  logic                        if_ready_i,
    input  logic [core_pkg::INST_W-1:0] if_data_i,
    output logic                        if_req_o,
    output logic [core_pkg::XLEN-1:0]   if_addr_o,
    output core_pkg::commit_t           commit_o,
    output logic                        halted_o,
    output logic [CNT_W-1:0]            cycle_cnt_o,
    output logic [CNT_W-1:0]            instret_o
);

    import core_pkg::*;

    fetch_pkt_t           fetch_pkt;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;

    fetch_ctrl #(
        .PC_START(PC_START)
    ) i_fetch_ctrl (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .if_ready_i              (if_ready_i),
        .if_data_i               (if_data_i),
        .if_req_o                (if_req_o),
        .if_addr_o               (if_addr_o),
        .fetch_o                 (fetch_pkt),
        .halted_o                (halted_o)
    );

    execute_stage i_execute_stage (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .fetch_i                 (fetch_pkt),
        .rs1_idx_o               (rs1_idx),
        .rs2_idx_o               (rs2_idx),
        .rs1_data_i              (rs1_data),
        .rs2_data_i              (rs2_data),
        .commit_o                (commit_o)
    );

    // commit doubles as the writeback port
    reg_file i_reg_file (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .rs1_idx_i               (rs1_idx),
        .rs2_idx_i               (rs2_idx),
        .rs1_data_o              (rs1_data),
        .rs2_data_o              (rs2_data),
        .wb_i                    (commit_o)
    );

    retire_counter #(
        .CNT_W(CNT_W)
    ) i_retire_counter (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .halted_i                (halted_o),
        .commit_i                (commit_o),
        .cycle_cnt_o             (cycle_cnt_o),
        .instret_o               (instret_o)
    );

endmodule

// ==== rtl/execute_stage.sv ====
module execute_stage (
    input  logic                           mem2wb_inst_selfdefine_o,
    input  logic                           reset,
    input  core_pkg::fetch_pkt_t           fetch_i,
    output logic [core_pkg::REG_IDX_W-1:0] rs1_idx_o,
    output logic [core_pkg::REG_IDX_W-1:0] rs2_idx_o,
    input  logic [core_pkg::XLEN-1:0]      rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]      rs2_data_i,
    output core_pkg::commit_t              commit_o
);

    import core_pkg::*;

    logic [6:0]           opcode;
    logic [REG_IDX_W-1:0] rd;
    logic [2:0]           funct3;
    logic                 sub_bit;
    logic [XLEN-1:0]      imm_i;
    logic [XLEN-1:0]      imm_u;
    logic [XLEN-1:0]      imm;
    alu_op_e              alu_op;
    logic                 f3_ok;
    logic                 use_imm;
    logic                 imm_sel_u;
    logic                 supported;
    logic [XLEN-1:0]      op_a;
    logic [XLEN-1:0]      rs2_val;
    logic [XLEN-1:0]      op_b;
    logic [XLEN-1:0]      alu_res;
    logic                 res_valid_q;
    logic                 res_wen_q;
    logic [REG_IDX_W-1:0] res_rd_q;
    logic [XLEN-1:0]      res_data_q;
    logic [XLEN-1:0]      res_pc_q;

    assign opcode    = fetch_i.inst[6:0];
    assign rd        = fetch_i.inst[11:7];
    assign funct3    = fetch_i.inst[14:12];
    assign sub_bit   = fetch_i.inst[30];
    assign rs1_idx_o = fetch_i.inst[19:15];
    assign rs2_idx_o = fetch_i.inst[24:20];

    assign imm_i = {{(XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
    assign imm_u = {fetch_i.inst[31:12], 12'b0};
    assign imm   = imm_sel_u ? imm_u : imm_i;

    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            // sub only exists in the register form
            F3_ADD: alu_op = (opcode == OPC_OP && sub_bit) ? ALU_SUB : ALU_ADD;
            F3_XOR: alu_op = ALU_XOR;
            F3_OR: alu_op = ALU_OR;
            F3_AND: alu_op = ALU_AND;
            default: begin
                alu_op = ALU_ADD;
                f3_ok  = 1'b0;
            end
        endcase
        use_imm   = 1'b0;
        imm_sel_u = 1'b0;
        supported = 1'b0;
        case (opcode)
            OPC_OP: supported = f3_ok;
            OPC_OP_IMM: begin
                supported = f3_ok;
                use_imm   = 1'b1;
            end
            OPC_LUI: begin
                supported = 1'b1;
                use_imm   = 1'b1;
                imm_sel_u = 1'b1;
                alu_op    = ALU_PASS_B;
            end
            default: supported = 1'b0;
        endcase
    end

    // result register still holds a write that has not reached the regfile
    assign op_a    = (res_valid_q && res_wen_q && res_rd_q == rs1_idx_o) ? res_data_q : rs1_data_i;
    assign rs2_val = (res_valid_q && res_wen_q && res_rd_q == rs2_idx_o) ? res_data_q : rs2_data_i;
    assign op_b    = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR: alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            default: alu_res = op_b;
        endcase
    end

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            res_valid_q <= 1'b0;
            res_wen_q   <= 1'b0;
        end else begin
            res_valid_q <= fetch_i.valid;
            res_wen_q   <= fetch_i.valid & supported & (rd != '0);
        end
    end

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (fetch_i.valid) begin
            res_rd_q   <= rd;
            // unsupported opcodes retire with zero data
            res_data_q <= supported ? alu_res : '0;
            res_pc_q   <= fetch_i.pc;
        end
    end

    assign commit_o = '{valid: res_valid_q, wen: res_wen_q, rd: res_rd_q,
                        data: res_data_q, pc: res_pc_q};

endmodule

// ==== rtl/fetch_ctrl.sv ====
module fetch_ctrl #(
    parameter logic [core_pkg::XLEN-1:0] PC_START = '0
) (
    input  logic                        mem2wb_inst_selfdefine_o,
    input  logic                        reset,
    input  logic                        if_ready_i,
    input  logic [core_pkg::INST_W-1:0] if_data_i,
    output logic                        if_req_o,
    output logic [core_pkg::XLEN-1:0]   if_addr_o,
    output core_pkg::fetch_pkt_t        fetch_o,
    output logic                        halted_o
);

    import core_pkg::*;

    typedef enum logic [1:0] {
        ST_BOOT  = 2'd0,
        ST_FETCH = 2'd1,
        ST_HALT  = 2'd2
    } state_e;

    state_e            state_q;
    state_e            state_d;
    logic [XLEN-1:0]   pc_q;
    logic              pkt_valid_q;
    logic [XLEN-1:0]   pkt_pc_q;
    logic [INST_W-1:0] pkt_inst_q;
    logic              accept;
    logic              is_halt;

    assign if_req_o  = (state_q == ST_FETCH);
    assign if_addr_o = pc_q;
    assign halted_o  = (state_q == ST_HALT);

    // word taken at this edge
    assign accept  = if_req_o & if_ready_i;
    assign is_halt = (if_data_i[6:0] == OPC_HALT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_BOOT: state_d = ST_FETCH;
            ST_FETCH: begin
                if (accept && is_halt) begin
                    state_d = ST_HALT;
                end
            end
            default: state_d = ST_HALT;
        endcase
    end

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            state_q     <= ST_BOOT;
            pc_q        <= PC_START;
            pkt_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            // halt word never enters the pipe
            pkt_valid_q <= accept & ~is_halt;
            if (accept) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (accept && !is_halt) begin
            pkt_pc_q   <= pc_q;
            pkt_inst_q <= if_data_i;
        end
    end

    assign fetch_o = '{valid: pkt_valid_q, pc: pkt_pc_q, inst: pkt_inst_q};

endmodule

// ==== rtl/reg_file.sv ====
module reg_file (
    input  logic                           mem2wb_inst_selfdefine_o,
    input  logic                           reset,
    input  logic [core_pkg::REG_IDX_W-1:0] rs1_idx_i,
    input  logic [core_pkg::REG_IDX_W-1:0] rs2_idx_i,
    output logic [core_pkg::XLEN-1:0]      rs1_data_o,
    output logic [core_pkg::XLEN-1:0]      rs2_data_o,
    input  core_pkg::commit_t              wb_i
);

    import core_pkg::*;

    localparam int NUM_REGS = 2**REG_IDX_W;

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:NUM_REGS-1];

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.wen && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

// ==== rtl/retire_counter.sv ====
module retire_counter #(
    parameter int CNT_W = 32
) (
    input  logic              mem2wb_inst_selfdefine_o,
    input  logic              reset,
    input  logic              halted_i,
    input  core_pkg::commit_t commit_i,
    output logic [CNT_W-1:0]  cycle_cnt_o,
    output logic [CNT_W-1:0]  instret_o
);

    always_ff @(posedge mem2wb_inst_selfdefine_o) begin
        if (reset) begin
            cycle_cnt_o <= '0;
            instret_o   <= '0;
        end else begin
            // cycle count freezes once the core halts
            if (!halted_i) begin
                cycle_cnt_o <= cycle_cnt_o + CNT_W'(1);
            end
            // every retirement counts, write or not
            if (commit_i.valid) begin
                instret_o <= instret_o + CNT_W'(1);
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds and runs the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core -f files.f \
    --Mdir "$OBJ_DIR" -o sim_tb_core > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/sim_tb_core" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== tb/tb_core.sv ====
module tb_core;

    import core_pkg::*;

    localparam logic [XLEN-1:0]   PC_START      = 32'h0000_0100;
    localparam int                CNT_W         = 32;
    localparam int                PROG_LEN      = 40;
    localparam int                HALT_TIMEOUT  = 1000;
    localparam int                DRAIN_TIMEOUT = 20;
    localparam int                IDLE_CYCLES   = 6;
    localparam logic [15:0]       LFSR_SEED     = 16'd64742;
    localparam logic [15:0]       LFSR_TAPS     = 16'hB400;
    localparam logic [INST_W-1:0] HALT_WORD     = {25'b0, OPC_HALT};

    typedef struct packed {
        commit_t     c;
        logic [31:0] due;
    } expect_t;

    logic              mem2wb_inst_selfdefine_o;
    logic              reset;
    logic              if_ready_i;
    logic [INST_W-1:0] if_data_i;
    logic              if_req_o;
    logic [XLEN-1:0]   if_addr_o;
    commit_t           commit;
    logic              halted;
    logic [CNT_W-1:0]  cycle_cnt;
    logic [CNT_W-1:0]  instret;

    logic [INST_W-1:0] prog [PROG_LEN];
    logic [XLEN-1:0]   ref_regs [32];
    logic [15:0]       lfsr_q;
    expect_t           exp_q [$];
    int                mismatches;
    int                failures;
    int                commits_seen;
    int                edge_no;
    int                halt_edge;
    int                delay_left;
    logic [XLEN-1:0]   exp_addr;
    logic              halt_seen;

    core_top #(
        .PC_START(PC_START),
        .CNT_W   (CNT_W)
    ) i_dut (
        .mem2wb_inst_selfdefine_o(mem2wb_inst_selfdefine_o),
        .reset                   (reset),
        .if_ready_i              (if_ready_i),
        .if_data_i               (if_data_i),
        .if_req_o                (if_req_o),
        .if_addr_o               (if_addr_o),
        .commit_o                (commit),
        .halted_o                (halted),
        .cycle_cnt_o             (cycle_cnt),
        .instret_o               (instret)
    );

    initial begin
        mem2wb_inst_selfdefine_o = 1'b0;
        forever #5 mem2wb_inst_selfdefine_o = ~mem2wb_inst_selfdefine_o;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = {1'b0, s[15:1]};
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [INST_W-1:0] encode_r(input logic sub, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [INST_W-1:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [INST_W-1:0] encode_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  prev_rd;
        logic [11:0] imm12;
        logic [19:0] imm20;
        prev_rd = 5'd0;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            // x0..x7 only, so registers get reused often
            draw_bits(3, r);
            rd = {2'b0, r[2:0]};
            draw_bits(3, r);
            rs1 = {2'b0, r[2:0]};
            draw_bits(3, r);
            rs2 = {2'b0, r[2:0]};
            draw_bits(12, r);
            imm12 = r[11:0];
            draw_bits(20, r);
            imm20 = r[19:0];
            // back-to-back dependent pairs
            if (i % 2 == 1) begin
                rs1 = prev_rd;
            end
            if (i % 4 == 2) begin
                rs2 = prev_rd;
            end
            if (i % 8 == 6) begin
                rd = 5'd0;
            end
            case (i % 10)
                0: prog[i] = encode_u(imm20, rd);
                1: prog[i] = encode_i(imm12, rs1, F3_ADD, rd);
                2: prog[i] = encode_r(1'b0, rs2, rs1, F3_ADD, rd);
                3: prog[i] = encode_i(imm12, rs1, F3_OR, rd);
                4: prog[i] = encode_r(1'b1, rs2, rs1, F3_ADD, rd);
                5: prog[i] = encode_i(imm12, rs1, F3_XOR, rd);
                6: prog[i] = encode_r(1'b0, rs2, rs1, F3_AND, rd);
                7: prog[i] = encode_i(imm12, rs1, F3_AND, rd);
                8: prog[i] = encode_r(1'b0, rs2, rs1, F3_OR, rd);
                default: prog[i] = encode_r(1'b0, rs2, rs1, F3_XOR, rd);
            endcase
            prev_rd = rd;
        end
        prog[PROG_LEN-1] = HALT_WORD;
    endtask

    function automatic logic [INST_W-1:0] fetch_word(input logic [XLEN-1:0] addr);
        int idx;
        idx = int'((addr - PC_START) >> 2);
        if (addr < PC_START || idx >= PROG_LEN) begin
            return HALT_WORD;
        end
        return prog[idx];
    endfunction

    function automatic logic expected_wen(input logic [INST_W-1:0] w);
        logic f3_kept;
        f3_kept = (w[14:12] == 3'b000) || (w[14:12] == 3'b100) ||
                  (w[14:12] == 3'b110) || (w[14:12] == 3'b111);
        if (w[11:7] == 5'd0) begin
            return 1'b0;
        end
        if (w[6:0] == OPC_LUI) begin
            return 1'b1;
        end
        if (w[6:0] == OPC_OP || w[6:0] == OPC_OP_IMM) begin
            return f3_kept;
        end
        return 1'b0;
    endfunction

    function automatic logic [XLEN-1:0] expected_result(input logic [INST_W-1:0] w,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic [XLEN-1:0] opnd;
        if (w[6:0] == OPC_LUI) begin
            return {w[31:12], 12'h000};
        end
        opnd = (w[6:0] == OPC_OP_IMM) ? {{20{w[31]}}, w[31:20]} : b;
        case (w[14:12])
            3'b000: return (w[6:0] == OPC_OP && w[30]) ? a - opnd : a + opnd;
            3'b100: return a ^ opnd;
            3'b110: return a | opnd;
            3'b111: return a & opnd;
            default: return '0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        mismatches++;
        $display("Mismatch at %0t: %s expected 0x%08h actual 0x%08h",
                 $time, name, exp_val, act_val);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // instruction memory with random ready delay of 0..3 cycles
    always @(posedge mem2wb_inst_selfdefine_o) begin
        logic [31:0]     d;
        logic [XLEN-1:0] next_addr;
        if (reset) begin
            if_ready_i <= 1'b0;
            if_data_i  <= fetch_word(PC_START);
            delay_left = 1;
        end else begin
            next_addr = (if_req_o && if_ready_i) ? if_addr_o + 32'd4 : if_addr_o;
            if_data_i <= fetch_word(next_addr);
            if (if_req_o && if_ready_i) begin
                draw_bits(2, d);
                delay_left = int'(d[1:0]);
                if_ready_i <= (d[1:0] == 2'd0);
            end else if (!if_ready_i) begin
                if (delay_left <= 1) begin
                    if_ready_i <= 1'b1;
                end else begin
                    delay_left--;
                end
            end
        end
    end

    // sees pre-edge values, so each accepting edge is caught here
    always @(posedge mem2wb_inst_selfdefine_o) begin
        expect_t           head;
        expect_t           item;
        logic [INST_W-1:0] w;
        if (reset) begin
            edge_no   = 0;
            halt_edge = 0;
            exp_addr  = PC_START;
            halt_seen = 1'b0;
            exp_q.delete();
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
        end else begin
            edge_no++;
            if (commit.valid) begin
                commits_seen++;
                if (exp_q.size() == 0) begin
                    report_failure("commit seen with no instruction outstanding");
                end else begin
                    head = exp_q.pop_front();
                    assert (commit.pc == head.c.pc)
                        else report_mismatch("commit_o.pc", head.c.pc, commit.pc);
                    assert (commit.rd == head.c.rd)
                        else report_mismatch("commit_o.rd", 32'(head.c.rd), 32'(commit.rd));
                    assert (commit.wen == head.c.wen)
                        else report_mismatch("commit_o.wen", 32'(head.c.wen), 32'(commit.wen));
                    assert (commit.data == head.c.data)
                        else report_mismatch("commit_o.data", head.c.data, commit.data);
                    assert (head.due == 32'(edge_no))
                        else report_mismatch("commit_o.valid edge", head.due, 32'(edge_no));
                end
            end else if (exp_q.size() > 0 && exp_q[0].due <= 32'(edge_no)) begin
                void'(exp_q.pop_front());
                report_failure("expected commit did not appear in time");
            end
            if (if_req_o) begin
                assert (if_addr_o == exp_addr)
                    else report_mismatch("if_addr_o", exp_addr, if_addr_o);
            end
            if (halt_seen) begin
                assert (halted && !if_req_o)
                    else report_failure("core not halted after the halt word was fetched");
            end
            if (if_req_o && if_ready_i) begin
                w        = if_data_i;
                exp_addr = exp_addr + 32'd4;
                if (w[6:0] == OPC_HALT) begin
                    halt_seen = 1'b1;
                    halt_edge = edge_no;
                end else begin
                    item.c.valid = 1'b1;
                    item.c.pc    = if_addr_o;
                    item.c.rd    = w[11:7];
                    item.c.wen   = expected_wen(w);
                    item.c.data  = expected_result(w, ref_regs[w[19:15]], ref_regs[w[24:20]]);
                    item.due     = 32'(edge_no + 2);
                    if (item.c.wen) begin
                        ref_regs[item.c.rd] = item.c.data;
                    end
                    exp_q.push_back(item);
                end
            end
        end
    end

    initial begin
        int               wait_cnt;
        logic [CNT_W-1:0] frozen_cnt;
        logic             timed_out;
        mismatches   = 0;
        failures     = 0;
        commits_seen = 0;
        timed_out    = 1'b0;
        lfsr_q       = LFSR_SEED;
        reset      <= 1'b1;
        if_ready_i <= 1'b0;
        if_data_i  <= '0;
        build_program();
        repeat (8) @(posedge mem2wb_inst_selfdefine_o);
        reset <= 1'b0;
        @(negedge mem2wb_inst_selfdefine_o);
        assert (!if_req_o) else report_failure("if_req_o high right after reset");
        assert (!halted) else report_failure("halted_o high right after reset");
        assert (!commit.valid) else report_failure("commit_o.valid high right after reset");
        assert (cycle_cnt == '0) else report_mismatch("cycle_cnt_o", 32'd0, cycle_cnt);
        assert (instret == '0) else report_mismatch("instret_o", 32'd0, instret);
        wait_cnt = 0;
        while (!halt_seen && wait_cnt < HALT_TIMEOUT) begin
            @(negedge mem2wb_inst_selfdefine_o);
            wait_cnt++;
        end
        if (!halt_seen) begin
            report_failure("timeout waiting for the halt word to be fetched");
            timed_out = 1'b1;
        end
        if (!timed_out) begin
            wait_cnt = 0;
            while (exp_q.size() > 0 && wait_cnt < DRAIN_TIMEOUT) begin
                @(negedge mem2wb_inst_selfdefine_o);
                wait_cnt++;
            end
            if (exp_q.size() > 0) begin
                report_failure("timeout waiting for outstanding commits");
                timed_out = 1'b1;
            end
        end
        if (!timed_out) begin
            @(negedge mem2wb_inst_selfdefine_o);
            frozen_cnt = cycle_cnt;
            // one count per edge up to and including the one that took the halt word
            assert (frozen_cnt == CNT_W'(halt_edge))
                else report_mismatch("cycle_cnt_o", 32'(halt_edge), frozen_cnt);
            repeat (IDLE_CYCLES) @(negedge mem2wb_inst_selfdefine_o);
            assert (halted) else report_failure("halted_o dropped after halt");
            assert (cycle_cnt == frozen_cnt)
                else report_mismatch("cycle_cnt_o", frozen_cnt, cycle_cnt);
            assert (instret == 32'(commits_seen))
                else report_mismatch("instret_o", 32'(commits_seen), instret);
            assert (commits_seen == PROG_LEN - 1)
                else report_mismatch("commit count", 32'(PROG_LEN - 1), 32'(commits_seen));
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
